// ==== source/fe_pkg.sv ====
// ==========================================================================
// front end shared definitions
// widths, exception causes and the structs passed between fetch blocks
// ==========================================================================

package fe_pkg;

  localparam int VADDR_W    = 32;
  localparam int LINE_BYTES = 8;
  localparam int LINE_W     = LINE_BYTES * 8;
  localparam int OFFS_W     = $clog2(LINE_BYTES);

  // committed exception causes, mcause numbering where one exists
  typedef enum logic [4:0] {
    INST_ACC_FAULT      = 5'd1,
    ILLEGAL_INST        = 5'd2,
    LOAD_ADDR_MISALIGN  = 5'd4,
    LOAD_ACC_FAULT      = 5'd5,
    STAMO_ADDR_MISALIGN = 5'd6,
    STAMO_ACC_FAULT     = 5'd7,
    ECALL_U             = 5'd8,
    ECALL_S             = 5'd9,
    ECALL_M             = 5'd11,
    SILENT_FLUSH        = 5'd16,
    MRET                = 5'd17,
    SRET                = 5'd18
  } except_t;

  typedef struct packed {
    logic               valid;
    logic               except_valid;
    except_t            except_type;
    logic [VADDR_W-1:0] epc;
  } commit_t;

  typedef struct packed {
    logic [VADDR_W-1:0] mepc;
    logic [VADDR_W-1:0] sepc;
    logic [VADDR_W-1:0] mtvec;
    logic [VADDR_W-1:0] stvec;
    logic [15:0]        medeleg;
  } csr_vec_t;

  typedef struct packed {
    logic               valid;
    logic               mispredict;
    logic               taken;
    logic [VADDR_W-1:0] pc;
    logic [VADDR_W-1:0] target;
  } br_upd_t;

  typedef struct packed {
    logic               valid;
    logic [VADDR_W-1:0] pc;       // exact fetch address
    logic [LINE_W-1:0]  data;     // whole aligned line
  } fetch_pkt_t;

  typedef struct packed {
    logic               valid;
    logic [VADDR_W-1:0] addr;     // line aligned
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [LINE_W-1:0] data;
  } mem_resp_t;

  typedef enum logic [2:0] {
    INIT           = 3'd0,
    FETCH          = 3'd1,
    WAIT_IC_FILL   = 3'd2,
    WAIT_IBUF_FREE = 3'd3,
    WAIT_REDIRECT  = 3'd4
  } fetch_state_t;

endpackage

// ==== source/fe_redirect.sv ====
// ==========================================================================
// fetch redirect select
// new fetch PC from committed exceptions and branch mispredicts
// ==========================================================================

`timescale 1ns/100ps

module fe_redirect (
  input  fe_pkg::commit_t              i_commit,
  input  fe_pkg::csr_vec_t             i_csr,
  input  fe_pkg::br_upd_t              i_br_upd,
  output logic                         o_redirect,
  output logic [fe_pkg::VADDR_W-1:0]   o_redirect_pc
);

  import fe_pkg::*;

  logic               w_commit_flush;
  logic               w_br_flush;
  logic [4:0]         w_cause;
  logic               w_delegated;
  logic [VADDR_W-1:0] w_trap_pc;

  assign w_commit_flush = i_commit.valid & i_commit.except_valid;
  assign w_br_flush     = i_br_upd.valid & i_br_upd.mispredict;

  // medeleg only covers the low 16 causes
  assign w_cause     = i_commit.except_type;
  assign w_delegated = ~w_cause[4] & i_csr.medeleg[w_cause[3:0]];
  assign w_trap_pc   = w_delegated ? i_csr.stvec : i_csr.mtvec;

  assign o_redirect = w_commit_flush | w_br_flush;

  // commit side wins over a same cycle branch update
  always_comb begin
    o_redirect_pc = '0;
    if (w_commit_flush) begin
      case (i_commit.except_type)
        SILENT_FLUSH : o_redirect_pc = i_commit.epc + VADDR_W'(4);
        MRET         : o_redirect_pc = i_csr.mepc;
        SRET         : o_redirect_pc = i_csr.sepc;
        default      : o_redirect_pc = w_trap_pc;   // real trap
      endcase
    end else if (w_br_flush) begin
      o_redirect_pc = i_br_upd.target;
    end
  end

endmodule

// ==== source/fe_btb.sv ====
// ==========================================================================
// branch target buffer
// direct mapped on the line PC, trained by resolved branches
// ==========================================================================

`timescale 1ns/100ps

module fe_btb #(
  parameter int BTB_ENTRIES = 8
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_s0_valid,
  input  logic [fe_pkg::VADDR_W-1:0] i_s0_pc,
  input  fe_pkg::br_upd_t            i_br_upd,
  output logic                       o_s1_hit,
  output logic [fe_pkg::VADDR_W-1:0] o_s1_target
);

  import fe_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = VADDR_W - OFFS_W - IDX_W;

  logic [BTB_ENTRIES-1:0] r_valid;
  logic [TAG_W-1:0]       r_tag    [BTB_ENTRIES];
  logic [VADDR_W-1:0]     r_target [BTB_ENTRIES];

  logic [IDX_W-1:0]       w_upd_idx;
  logic [TAG_W-1:0]       w_upd_tag;
  logic [IDX_W-1:0]       w_s0_idx;
  logic [TAG_W-1:0]       w_s0_tag;

  assign w_upd_idx = i_br_upd.pc[OFFS_W +: IDX_W];
  assign w_upd_tag = i_br_upd.pc[VADDR_W-1 -: TAG_W];
  assign w_s0_idx  = i_s0_pc[OFFS_W +: IDX_W];
  assign w_s0_tag  = i_s0_pc[VADDR_W-1 -: TAG_W];

  // ========================================================================
  // update
  // ========================================================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_br_upd.valid) begin
      r_valid[w_upd_idx] <= i_br_upd.taken;   // not taken drops the entry
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_br_upd.valid & i_br_upd.taken) begin
      r_tag[w_upd_idx]    <= w_upd_tag;
      r_target[w_upd_idx] <= i_br_upd.target;
    end
  end

  // ========================================================================
  // lookup, result one cycle after s0
  // ========================================================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_s1_hit <= 1'b0;
    end else begin
      o_s1_hit <= i_s0_valid & r_valid[w_s0_idx] & (r_tag[w_s0_idx] == w_s0_tag);
    end
  end

  always_ff @(posedge i_clk) begin
    o_s1_target <= r_target[w_s0_idx];
  end

endmodule

// ==== source/fe_icache.sv ====
// ==========================================================================
// instruction cache
// direct mapped, one line per fetch, single outstanding refill to memory
// ==========================================================================

`timescale 1ns/100ps

module fe_icache #(
  parameter int IC_LINES = 16
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_s0_valid,
  input  logic [fe_pkg::VADDR_W-1:0] i_s0_pc,
  input  logic                       i_kill,
  output logic                       o_s1_hit,
  output logic                       o_s1_miss,
  output logic [fe_pkg::LINE_W-1:0]  o_s1_data,
  output fe_pkg::mem_req_t           o_mem_req,
  input  fe_pkg::mem_resp_t          i_mem_resp,
  output logic                       o_fill_done
);

  import fe_pkg::*;

  localparam int IDX_W = $clog2(IC_LINES);
  localparam int TAG_W = VADDR_W - OFFS_W - IDX_W;

  // arrays
  logic [IC_LINES-1:0] r_valid;
  logic [TAG_W-1:0]    r_tag  [IC_LINES];
  logic [LINE_W-1:0]   r_data [IC_LINES];

  // s1 address
  logic                r_s1_valid;
  logic [VADDR_W-1:0]  r_s1_pc;
  logic [IDX_W-1:0]    w_s1_idx;
  logic [TAG_W-1:0]    w_s1_tag;
  logic                w_s1_match;

  // refill
  logic                r_busy;
  logic                r_req_valid;
  logic [VADDR_W-1:0]  r_req_addr;
  logic                r_fill_done;
  logic                w_refill_start;
  logic                w_fill;
  logic [IDX_W-1:0]    w_fill_idx;

  // ========================================================================
  // s0 -> s1
  // ========================================================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_s0_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_pc <= i_s0_pc;
  end

  // ========================================================================
  // s1 tag compare
  // ========================================================================
  assign w_s1_idx   = r_s1_pc[OFFS_W +: IDX_W];
  assign w_s1_tag   = r_s1_pc[VADDR_W-1 -: TAG_W];
  assign w_s1_match = r_valid[w_s1_idx] & (r_tag[w_s1_idx] == w_s1_tag);

  assign o_s1_hit  = r_s1_valid & ~i_kill & w_s1_match;
  assign o_s1_miss = r_s1_valid & ~i_kill & ~w_s1_match;
  assign o_s1_data = r_data[w_s1_idx];

  // ========================================================================
  // refill
  // ========================================================================
  // a miss seen while busy is left to the controller, which refetches
  // after the fill in flight has landed
  assign w_refill_start = o_s1_miss & ~r_busy;
  assign w_fill         = i_mem_resp.valid & r_busy;
  assign w_fill_idx     = r_req_addr[OFFS_W +: IDX_W];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy      <= 1'b0;
      r_req_valid <= 1'b0;
      r_fill_done <= 1'b0;
      r_valid     <= '0;
    end else begin
      r_req_valid <= w_refill_start;    // one cycle pulse
      r_fill_done <= w_fill;
      if (w_refill_start) begin
        r_busy <= 1'b1;
      end else if (w_fill) begin
        r_busy <= 1'b0;
      end
      if (w_fill) begin
        r_valid[w_fill_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_refill_start) begin
      r_req_addr <= {r_s1_pc[VADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    end
    if (w_fill) begin
      r_tag[w_fill_idx]  <= r_req_addr[VADDR_W-1 -: TAG_W];
      r_data[w_fill_idx] <= i_mem_resp.data;
    end
  end

  assign o_mem_req.valid = r_req_valid;
  assign o_mem_req.addr  = r_req_addr;
  assign o_fill_done     = r_fill_done;   // line is readable from this cycle

endmodule

// ==== source/fe_fetch_ctrl.sv ====
// ==========================================================================
// fetch controller
// fetch state machine, s0/s1 PC sequencing and fetch packet output
// ==========================================================================

`timescale 1ns/100ps

module fe_fetch_ctrl #(
  parameter logic [fe_pkg::VADDR_W-1:0] RESET_PC = 32'h0000_1000
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_redirect,
  input  logic [fe_pkg::VADDR_W-1:0] i_redirect_pc,
  input  logic                       i_s1_hit,
  input  logic                       i_s1_miss,
  input  logic [fe_pkg::LINE_W-1:0]  i_s1_data,
  input  logic                       i_btb_hit,
  input  logic [fe_pkg::VADDR_W-1:0] i_btb_target,
  input  logic                       i_fill_done,
  input  logic                       i_ibuf_ready,
  output logic                       o_s0_valid,
  output logic [fe_pkg::VADDR_W-1:0] o_s0_pc,
  output logic                       o_kill,
  output fe_pkg::fetch_pkt_t         o_fetch
);

  import fe_pkg::*;

  fetch_state_t       r_state;
  fetch_state_t       w_state_next;
  logic [VADDR_W-1:0] r_s0_pc;       // pending PC while s1 is empty
  logic [VADDR_W-1:0] w_hold_pc;
  logic               r_s1_valid;
  logic [VADDR_W-1:0] r_s1_pc;
  logic               w_s1_live;
  logic [VADDR_W-1:0] w_seq_pc;
  logic               w_s0_valid;
  logic [VADDR_W-1:0] w_s0_pc;

  assign w_s1_live = r_s1_valid & ~i_redirect;
  assign w_seq_pc  = {r_s1_pc[VADDR_W-1:OFFS_W], {OFFS_W{1'b0}}} + VADDR_W'(LINE_BYTES);

  // ========================================================================
  // next state and s0 select
  // ========================================================================
  always_comb begin
    w_state_next = r_state;
    w_s0_valid   = 1'b0;
    w_s0_pc      = r_s0_pc;
    w_hold_pc    = r_s0_pc;
    if (i_redirect) begin
      w_s0_valid = 1'b1;
      w_s0_pc    = i_redirect_pc;
      // a refill may still be in flight behind the redirect
      if ((r_state == WAIT_IC_FILL) || (r_state == WAIT_REDIRECT)) begin
        w_state_next = WAIT_REDIRECT;
      end else begin
        w_state_next = FETCH;
      end
    end else begin
      case (r_state)
        INIT : w_state_next = FETCH;
        FETCH, WAIT_REDIRECT : begin
          if (w_s1_live & i_s1_miss) begin
            w_hold_pc    = r_s1_pc;       // refetch after fill
            w_state_next = WAIT_IC_FILL;
          end else if (w_s1_live & i_s1_hit & ~i_ibuf_ready) begin
            w_hold_pc    = r_s1_pc;       // packet not taken
            w_state_next = WAIT_IBUF_FREE;
          end else begin
            w_s0_valid = 1'b1;
            if (w_s1_live & i_s1_hit) begin
              w_s0_pc = i_btb_hit ? i_btb_target : w_seq_pc;
            end
            if ((r_state == WAIT_REDIRECT) & i_fill_done) begin
              w_state_next = FETCH;       // stale refill drained
            end
          end
        end
        WAIT_IC_FILL : begin
          if (i_fill_done) begin
            w_s0_valid   = 1'b1;
            w_state_next = FETCH;
          end
        end
        WAIT_IBUF_FREE : begin
          if (i_ibuf_ready) begin
            w_s0_valid   = 1'b1;
            w_state_next = FETCH;
          end
        end
        default : w_state_next = INIT;
      endcase
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= INIT;
      r_s0_pc    <= RESET_PC;
      r_s1_valid <= 1'b0;
    end else begin
      r_state    <= w_state_next;
      r_s0_pc    <= w_hold_pc;
      r_s1_valid <= w_s0_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_pc <= w_s0_pc;
  end

  assign o_s0_valid = w_s0_valid;
  assign o_s0_pc    = w_s0_pc;
  assign o_kill     = i_redirect;   // drops the s1 entry

  assign o_fetch.valid = w_s1_live & i_s1_hit;
  assign o_fetch.pc    = r_s1_pc;
  assign o_fetch.data  = i_s1_data;

endmodule

// ==== source/fe_frontend.sv ====
// ==========================================================================
// instruction fetch front end
// fetch controller with cache, branch target buffer and redirect select
// ==========================================================================

`timescale 1ns/100ps

module fe_frontend #(
  parameter int                         IC_LINES    = 16,
  parameter int                         BTB_ENTRIES = 8,
  parameter logic [fe_pkg::VADDR_W-1:0] RESET_PC    = 32'h0000_1000
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  fe_pkg::commit_t    i_commit,
  input  fe_pkg::csr_vec_t   i_csr,
  input  fe_pkg::br_upd_t    i_br_upd,
  input  logic               i_ibuf_ready,
  output fe_pkg::fetch_pkt_t o_fetch,
  output fe_pkg::mem_req_t   o_mem_req,
  input  fe_pkg::mem_resp_t  i_mem_resp
);

  import fe_pkg::*;

  logic               w_redirect;
  logic [VADDR_W-1:0] w_redirect_pc;
  logic               w_s0_valid;
  logic [VADDR_W-1:0] w_s0_pc;
  logic               w_kill;
  logic               w_s1_hit;
  logic               w_s1_miss;
  logic [LINE_W-1:0]  w_s1_data;
  logic               w_fill_done;
  logic               w_btb_hit;
  logic [VADDR_W-1:0] w_btb_target;

  fe_redirect u_redirect (
    .i_commit      (i_commit),
    .i_csr         (i_csr),
    .i_br_upd      (i_br_upd),
    .o_redirect    (w_redirect),
    .o_redirect_pc (w_redirect_pc)
  );

  fe_btb #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_s0_valid  (w_s0_valid),
    .i_s0_pc     (w_s0_pc),
    .i_br_upd    (i_br_upd),
    .o_s1_hit    (w_btb_hit),
    .o_s1_target (w_btb_target)
  );

  fe_icache #(.IC_LINES(IC_LINES)) u_icache (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_s0_valid  (w_s0_valid),
    .i_s0_pc     (w_s0_pc),
    .i_kill      (w_kill),
    .o_s1_hit    (w_s1_hit),
    .o_s1_miss   (w_s1_miss),
    .o_s1_data   (w_s1_data),
    .o_mem_req   (o_mem_req),
    .i_mem_resp  (i_mem_resp),
    .o_fill_done (w_fill_done)
  );

  fe_fetch_ctrl #(.RESET_PC(RESET_PC)) u_fetch_ctrl (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_redirect    (w_redirect),
    .i_redirect_pc (w_redirect_pc),
    .i_s1_hit      (w_s1_hit),
    .i_s1_miss     (w_s1_miss),
    .i_s1_data     (w_s1_data),
    .i_btb_hit     (w_btb_hit),
    .i_btb_target  (w_btb_target),
    .i_fill_done   (w_fill_done),
    .i_ibuf_ready  (i_ibuf_ready),
    .o_s0_valid    (w_s0_valid),
    .o_s0_pc       (w_s0_pc),
    .o_kill        (w_kill),
    .o_fetch       (o_fetch)
  );

endmodule

// ==== dv/fe_frontend_assertions.sv ====
// ==========================================================================
// front end protocol assertions
// refill request pulse rules and redirect kill, bound to the top level
// ==========================================================================

`timescale 1ns/100ps

module fe_frontend_assertions (
  input logic                       i_clk,
  input logic                       i_reset_n,
  input logic                       i_redirect,
  input logic [fe_pkg::VADDR_W-1:0] i_redirect_pc,
  input fe_pkg::fetch_pkt_t         i_fetch,
  input fe_pkg::mem_req_t           i_mem_req,
  input fe_pkg::mem_resp_t          i_mem_resp
);

  logic r_refill_pending;   // request sent, line not back yet

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_refill_pending <= 1'b0;
    end else if (i_mem_req.valid) begin
      r_refill_pending <= 1'b1;
    end else if (i_mem_resp.valid) begin
      r_refill_pending <= 1'b0;
    end
  end

  req_one_cycle : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_mem_req.valid |=> !i_mem_req.valid)
    else $error("refill request held for more than one cycle");

  req_single_outstanding : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_mem_req.valid |-> !r_refill_pending)
    else $error("second refill request while one is outstanding");

  // killed in the redirect cycle, and a packet right after carries the target
  redirect_kills_fetch : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_redirect |-> !i_fetch.valid ##1
      (!i_fetch.valid || (i_fetch.pc == $past(i_redirect_pc))))
    else $error("fetch packet wrong around a redirect");

endmodule

bind fe_frontend fe_frontend_assertions u_assertions (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_redirect    (w_redirect),
  .i_redirect_pc (w_redirect_pc),
  .i_fetch       (o_fetch),
  .i_mem_req     (o_mem_req),
  .i_mem_resp    (i_mem_resp)
);

// ==== dv/fe_frontend_tb.sv ====
// ==========================================================================
// fetch front end testbench
// memory model, reference PC tracker and packet checker around the DUT
// ==========================================================================

`timescale 1ns/100ps

module fe_frontend_tb;

  import fe_pkg::*;

  localparam int                 IC_LINES        = 16;
  localparam int                 BTB_ENTRIES     = 8;
  localparam logic [VADDR_W-1:0] RESET_PC        = 32'h0000_1000;
  localparam int                 BTB_IDX_W       = $clog2(BTB_ENTRIES);
  localparam int                 TOTAL_PKTS      = 100;
  localparam int                 PKT_CYCLES      = 30;   // refill of 6 plus ready gaps
  localparam int                 WATCHDOG_CYCLES = TOTAL_PKTS * PKT_CYCLES + 40;

  logic       i_clk;
  logic       i_reset_n;
  commit_t    i_commit;
  csr_vec_t   i_csr;
  br_upd_t    i_br_upd;
  logic       i_ibuf_ready;
  fetch_pkt_t o_fetch;
  mem_req_t   o_mem_req;
  mem_resp_t  i_mem_resp;

  // reference state
  logic [VADDR_W-1:0]     exp_pc     = RESET_PC;
  logic [BTB_ENTRIES-1:0] btb_valid  = '0;
  logic [VADDR_W-1:0]     btb_line [BTB_ENTRIES];
  logic [VADDR_W-1:0]     btb_tgt  [BTB_ENTRIES];
  int                     n_accepted = 0;
  int                     n_errors   = 0;

  fe_frontend #(
    .IC_LINES    (IC_LINES),
    .BTB_ENTRIES (BTB_ENTRIES),
    .RESET_PC    (RESET_PC)
  ) u_dut (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_commit     (i_commit),
    .i_csr        (i_csr),
    .i_br_upd     (i_br_upd),
    .i_ibuf_ready (i_ibuf_ready),
    .o_fetch      (o_fetch),
    .o_mem_req    (o_mem_req),
    .i_mem_resp   (i_mem_resp)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // ========================================================================
  // reference model
  // ========================================================================
  function automatic logic [31:0] mem_word(input logic [VADDR_W-1:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[7:0], addr[31:8]};
  endfunction

  function automatic logic [LINE_W-1:0] line_data(input logic [VADDR_W-1:0] line);
    return {mem_word(line + 32'd4), mem_word(line)};
  endfunction

  function automatic logic [VADDR_W-1:0] line_of(input logic [VADDR_W-1:0] pc);
    return pc & ~VADDR_W'(LINE_BYTES - 1);
  endfunction

  // taken prediction from the trained entries, else next line
  function automatic logic [VADDR_W-1:0] predict_next(input logic [VADDR_W-1:0] pc);
    logic [BTB_IDX_W-1:0] idx;
    idx = pc[OFFS_W +: BTB_IDX_W];
    if (btb_valid[idx] && (btb_line[idx] == line_of(pc))) begin
      return btb_tgt[idx];
    end
    return line_of(pc) + VADDR_W'(LINE_BYTES);
  endfunction

  function automatic logic [VADDR_W-1:0] redirect_target(input commit_t c,
                                                         input csr_vec_t csr,
                                                         input br_upd_t br);
    logic [4:0]         cause;
    logic [VADDR_W-1:0] target;
    cause  = c.except_type;
    target = br.target;
    if (c.valid && c.except_valid) begin
      case (c.except_type)
        SILENT_FLUSH : target = c.epc + 32'd4;
        MRET         : target = csr.mepc;
        SRET         : target = csr.sepc;
        default      : target = ((cause < 5'd16) && csr.medeleg[cause[3:0]]) ?
                                csr.stvec : csr.mtvec;
      endcase
    end
    return target;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      n_errors++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // ========================================================================
  // stimulus tasks
  // ========================================================================
  task automatic run_packets(input int count, input bit gaps);
    int goal;
    goal = n_accepted + count;
    while (n_accepted < goal) begin
      @(negedge i_clk);
      i_ibuf_ready = gaps ? ($urandom_range(3, 0) != 0) : 1'b1;
    end
  endtask

  task automatic raise_exception(input except_t cause, input logic [VADDR_W-1:0] epc);
    @(negedge i_clk);
    i_commit.valid        = 1'b1;
    i_commit.except_valid = 1'b1;
    i_commit.except_type  = cause;
    i_commit.epc          = epc;
    @(negedge i_clk);
    i_commit = '0;
  endtask

  task automatic resolve_branch(input logic taken, input logic [VADDR_W-1:0] pc,
                                input logic [VADDR_W-1:0] target);
    @(negedge i_clk);
    i_br_upd.valid      = 1'b1;
    i_br_upd.mispredict = 1'b1;
    i_br_upd.taken      = taken;
    i_br_upd.pc         = pc;
    i_br_upd.target     = target;
    @(negedge i_clk);
    i_br_upd = '0;
  endtask

  // memory answers each refill after 1 to 6 cycles
  initial begin : memory_model
    logic [VADDR_W-1:0] addr;
    int unsigned        delay;
    i_mem_resp = '0;
    forever begin
      @(posedge i_clk);
      if (i_reset_n && o_mem_req.valid) begin
        addr  = o_mem_req.addr;
        delay = $urandom_range(6, 1);
        repeat (delay - 1) @(posedge i_clk);
        @(negedge i_clk);
        i_mem_resp.valid = 1'b1;
        i_mem_resp.data  = line_data(addr);
        @(negedge i_clk);
        i_mem_resp = '0;
      end
    end
  end

  // ========================================================================
  // packet compare and reference PC tracking
  // ========================================================================
  always @(posedge i_clk) begin : compare_packets
    logic [BTB_IDX_W-1:0] idx;
    if (i_reset_n) begin
      if (o_fetch.valid && i_ibuf_ready) begin
        check_value("o_fetch.pc", 64'(o_fetch.pc), 64'(exp_pc));
        check_value("o_fetch.data", o_fetch.data, line_data(line_of(exp_pc)));
        exp_pc = predict_next(exp_pc);
        n_accepted++;
      end
      if ((i_commit.valid && i_commit.except_valid) ||
          (i_br_upd.valid && i_br_upd.mispredict)) begin
        check_value("o_fetch.valid", 64'(o_fetch.valid), 64'd0);   // s1 killed
        exp_pc = redirect_target(i_commit, i_csr, i_br_upd);
      end
      if (i_br_upd.valid) begin
        idx            = i_br_upd.pc[OFFS_W +: BTB_IDX_W];
        btb_valid[idx] = i_br_upd.taken;
        btb_line[idx]  = line_of(i_br_upd.pc);
        btb_tgt[idx]   = i_br_upd.target;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("timeout: fetch stalled after %0d accepted packets", n_accepted);
    $display("Some tests failed");
    $finish;
  end

  initial begin : main_sequence
    void'($urandom(41));
    i_reset_n     = 1'b0;
    i_commit      = '0;
    i_br_upd      = '0;
    i_ibuf_ready  = 1'b1;
    i_csr.mepc    = 32'h0000_4004;   // mid-line return address
    i_csr.sepc    = 32'h0000_5000;
    i_csr.mtvec   = 32'h0000_6000;
    i_csr.stvec   = 32'h0000_7000;
    i_csr.medeleg = 16'h0100;        // only ECALL_U delegated
    repeat (10) @(negedge i_clk);
    check_value("o_fetch.valid", 64'(o_fetch.valid), 64'd0);
    check_value("o_mem_req.valid", 64'(o_mem_req.valid), 64'd0);
    i_reset_n = 1'b1;
    @(negedge i_clk);
    check_value("o_fetch.valid", 64'(o_fetch.valid), 64'd0);
    check_value("o_mem_req.valid", 64'(o_mem_req.valid), 64'd0);

    // sequential, cold misses then the same lines again as hits
    run_packets(12, 1'b0);
    raise_exception(SILENT_FLUSH, 32'h0000_0FFC);
    run_packets(12, 1'b0);
    run_packets(40, 1'b1);           // ready gaps

    // mispredict trains 0x2010 -> 0x3000, then run through that line
    resolve_branch(1'b1, 32'h0000_2010, 32'h0000_3000);
    run_packets(4, 1'b1);
    raise_exception(SILENT_FLUSH, 32'h0000_1FFC);
    run_packets(6, 1'b0);
    resolve_branch(1'b0, 32'h0000_2010, 32'h0000_2018);
    run_packets(2, 1'b0);
    raise_exception(SILENT_FLUSH, 32'h0000_1FFC);
    run_packets(4, 1'b1);

    // trap returns and ecalls
    raise_exception(MRET, '0);
    run_packets(3, 1'b1);
    raise_exception(SRET, '0);
    run_packets(3, 1'b0);
    raise_exception(ECALL_U, 32'h0000_2008);
    run_packets(3, 1'b1);
    raise_exception(ECALL_M, 32'h0000_7008);
    run_packets(3, 1'b0);

    repeat (5) @(negedge i_clk);
    $display("accepted packets %0d, errors %0d", n_accepted, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
source/fe_pkg.sv
source/fe_redirect.sv
source/fe_btb.sv
source/fe_icache.sv
source/fe_fetch_ctrl.sv
source/fe_frontend.sv
dv/fe_frontend_assertions.sv
dv/fe_frontend_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -Mdir obj_dir --top-module fe_frontend_tb -o fe_frontend_sim -f project.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/fe_frontend_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
exit 0
